//--- all.f
verilog/scan_cfg_pkg.sv
verilog/scan_pipe_pkg.sv
verilog/scan_cfg_decode.sv
verilog/video_timing_gen.sv
verilog/pipe_delay.sv
verilog/scanline_gen.sv
verilog/output_compose.sv
verilog/scan_converter_top.sv
test/scan_monitor.sv
test/scan_converter_chk.sv
test/tb_scan_converter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the scan converter testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_scan_converter -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_scan_converter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
    echo "Simulation PASSED"
    exit 0
else
    echo "Simulation FAILED"
    exit 1
fi

//--- test/tb_scan_converter.sv
// Testbench for the scan converter output stage
// Random configurations and frame pixels, DUT and monitor, closing report
`timescale 1ns/1ps
`default_nettype none

module tb_scan_converter;
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    localparam int NUM_CFGS       = 3;
    localparam int FRAMES_PER_CFG = 2;
    localparam int WAIT_LIMIT     = 4000;

    logic           pclk_out = 1'b0;
    logic           rst_n;
    logic [31:0]    hv_word;
    logic [31:0]    hv2_word;
    logic [31:0]    hv3_word;
    logic [31:0]    win_word;
    logic [31:0]    sl_word;
    logic [31:0]    misc_word;
    pixel_t         pix;
    logic [7:0]     r;
    logic [7:0]     g;
    logic [7:0]     b;
    logic           hsync;
    logic           vsync;
    logic           de;
    logic [H_W-1:0] xpos;
    logic [V_W-1:0] ypos;
    timing_cfg_t    timing_set;
    window_cfg_t    window_set;
    sl_cfg_t        sl_set;
    mask_cfg_t      mask_set;
    integer         seed;
    int             tb_errors;
    int             mon_errors;
    int             mon_checks;
    logic           cfg_ok;

    always #20 pclk_out = ~pclk_out;

    scan_converter_top scan_converter_top_inst (
        .PCLK_OUT_i (pclk_out),
        .rst_n_i    (rst_n),
        .hv_cfg_i   (hv_word),
        .hv_cfg2_i  (hv2_word),
        .hv_cfg3_i  (hv3_word),
        .win_cfg_i  (win_word),
        .sl_cfg_i   (sl_word),
        .misc_cfg_i (misc_word),
        .pix_i      (pix),
        .R_o        (r),
        .G_o        (g),
        .B_o        (b),
        .HSYNC_o    (hsync),
        .VSYNC_o    (vsync),
        .DE_o       (de),
        .xpos_o     (xpos),
        .ypos_o     (ypos)
    );

    scan_monitor scan_monitor_inst (
        .PCLK_OUT_i    (pclk_out),
        .rst_n_i       (rst_n),
        .timing_i      (timing_set),
        .window_i      (window_set),
        .sl_i          (sl_set),
        .mask_i        (mask_set),
        .pix_i         (pix),
        .r_i           (r),
        .g_i           (g),
        .b_i           (b),
        .hsync_i       (hsync),
        .vsync_i       (vsync),
        .de_i          (de),
        .xpos_i        (xpos),
        .ypos_i        (ypos),
        .err_count_o   (mon_errors),
        .check_count_o (mon_checks)
    );

    function automatic int rand_in(input int lo, input int hi);
        int span;
        span = hi - lo + 1;
        return lo + int'($unsigned($random(seed)) % span);
    endfunction

    // Small legal timing with the window kept inside the active area
    task automatic make_config(input int idx);
        int hact;
        int vact;
        int xo;
        int yo;
        hact                   = rand_in(8, 24);
        vact                   = rand_in(4, 10);
        timing_set             = '0;
        timing_set.h_synclen   = 8'(rand_in(2, 7));
        timing_set.h_backporch = 9'(rand_in(1, 6));
        timing_set.h_active    = H_W'(hact);
        timing_set.h_total     = H_W'(int'(timing_set.h_synclen) +
                                      int'(timing_set.h_backporch) + hact + rand_in(2, 6));
        timing_set.v_synclen   = 4'(rand_in(1, 3));
        timing_set.v_backporch = 9'(rand_in(1, 3));
        timing_set.v_active    = V_W'(vact);
        timing_set.v_total     = V_W'(int'(timing_set.v_synclen) +
                                      int'(timing_set.v_backporch) + vact + rand_in(1, 3));
        xo                     = rand_in(0, hact - 1);
        yo                     = rand_in(0, vact - 1);
        window_set.x_offset    = H_W'(xo);
        window_set.x_size      = H_W'(rand_in(1, hact - xo));
        window_set.y_offset    = V_W'(yo);
        window_set.y_size      = V_W'(rand_in(1, vact - yo));
        sl_set.str             = 24'($random(seed));
        sl_set.overlay         = 6'($random(seed));
        sl_set.interval        = 3'(rand_in(0, SL_ROWS - 1));
        mask_set.br            = 4'(rand_in(0, 15));
        mask_set.color         = 3'(rand_in(1, 7));
        mask_set.tp_en         = (idx == 1);

        hv_word   = {timing_set.h_synclen, timing_set.h_active, timing_set.h_total};
        hv2_word  = {1'b0, timing_set.v_active, timing_set.v_total, timing_set.h_backporch};
        hv3_word  = {8'h00, window_set.y_offset, timing_set.v_backporch, timing_set.v_synclen};
        win_word  = {8'h00, window_set.x_size, window_set.x_offset};
        sl_word   = {2'b00, sl_set.overlay, sl_set.str};
        misc_word = {10'h000, sl_set.interval, window_set.y_size,
                     mask_set.tp_en, mask_set.color, mask_set.br};
        $display("Config %0d: H total %0d, V total %0d, test pattern %0b",
                 idx, timing_set.h_total, timing_set.v_total, mask_set.tp_en);
    endtask

    task automatic finish_run();
        if (mon_checks == 0) begin
            tb_errors++;
            $display("No DUT output was ever checked");
        end
        $display("Checks: %0d, monitor errors: %0d, testbench errors: %0d",
                 mon_checks, mon_errors, tb_errors);
        if (mon_errors == 0 && tb_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    // Returns on the falling edge where VSYNC_o is first seen low
    task automatic wait_frame_start(output logic found);
        int   cycles;
        logic seen_high;
        cycles    = 0;
        seen_high = 1'b0;
        found     = 1'b0;
        while (!found && cycles < WAIT_LIMIT) begin
            @(negedge pclk_out);
            cycles++;
            if (vsync) begin
                seen_high = 1'b1;
            end else if (seen_high) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            tb_errors++;
            $display("Timeout: VSYNC_o did not start a new frame within %0d cycles", WAIT_LIMIT);
        end
    endtask

    task automatic run_config(input int idx, output logic ok);
        @(negedge pclk_out);
        rst_n = 1'b0;
        make_config(idx);
        pix = 24'($random(seed));
        repeat (8) @(negedge pclk_out);
        rst_n = 1'b1;
        ok    = 1'b1;
        // Startup fall plus one fall at the end of each full frame
        for (int f = 0; f <= FRAMES_PER_CFG && ok; f++) begin
            wait_frame_start(ok);
            pix = 24'($random(seed));
        end
    endtask

    initial begin
        seed      = 32'h093a_a1dc;
        tb_errors = 0;
        cfg_ok    = 1'b1;
        rst_n     = 1'b0;
        pix       = '0;
        hv_word   = '0;
        hv2_word  = '0;
        hv3_word  = '0;
        win_word  = '0;
        sl_word   = '0;
        misc_word = '0;
        for (int c = 0; c < NUM_CFGS && cfg_ok; c++) begin
            run_config(c, cfg_ok);
        end
        finish_run();
    end

endmodule

`default_nettype wire

//--- test/scan_converter_chk.sv
// Concurrent assertions on sync, DE and reset levels of the output stage
`timescale 1ns/1ps
`default_nettype none

module scan_converter_chk (
    input wire       PCLK_OUT_i,
    input wire       rst_n_i,
    input wire       hsync_i,
    input wire       vsync_i,
    input wire       de_i,
    input wire [7:0] r_i,
    input wire [7:0] g_i,
    input wire [7:0] b_i
);

    // DE lives in the active area, clear of both sync pulses
    de_outside_hsync: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i) !(de_i && !hsync_i))
        else $error("DE_o is high while HSYNC_o is low");

    de_outside_vsync: assert property (
        @(posedge PCLK_OUT_i) disable iff (!rst_n_i) !(de_i && !vsync_i))
        else $error("DE_o is high while VSYNC_o is low");

    // One cycle into reset all outputs sit at idle levels
    reset_idle: assert property (
        @(posedge PCLK_OUT_i) !rst_n_i |=> (hsync_i && vsync_i && !de_i &&
                                            r_i == 8'h00 && g_i == 8'h00 && b_i == 8'h00))
        else $error("Outputs are not at idle levels during reset");

endmodule

bind output_compose scan_converter_chk scan_converter_chk_inst (
    .PCLK_OUT_i (PCLK_OUT_i),
    .rst_n_i    (rst_n_i),
    .hsync_i    (HSYNC_o),
    .vsync_i    (VSYNC_o),
    .de_i       (DE_o),
    .r_i        (R_o),
    .g_i        (G_o),
    .b_i        (B_o)
);

`default_nettype wire

//--- test/scan_monitor.sv
// Output monitor for the scan converter
// Models frame timing and pixel rules, compares DUT outputs and counts errors
`timescale 1ns/1ps
`default_nettype none

module scan_monitor (
    input  wire                            PCLK_OUT_i,
    input  wire                            rst_n_i,
    input  wire scan_cfg_pkg::timing_cfg_t timing_i,
    input  wire scan_cfg_pkg::window_cfg_t window_i,
    input  wire scan_cfg_pkg::sl_cfg_t     sl_i,
    input  wire scan_cfg_pkg::mask_cfg_t   mask_i,
    input  wire scan_pipe_pkg::pixel_t     pix_i,
    input  wire [7:0]                      r_i,
    input  wire [7:0]                      g_i,
    input  wire [7:0]                      b_i,
    input  wire                            hsync_i,
    input  wire                            vsync_i,
    input  wire                            de_i,
    input  wire [scan_cfg_pkg::H_W-1:0]    xpos_i,
    input  wire [scan_cfg_pkg::V_W-1:0]    ypos_i,
    output int                             err_count_o,
    output int                             check_count_o
);
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    int   errors = 0;
    int   checks = 0;
    logic hsync_q;
    logic vsync_q;
    logic de_q;
    logic pulse_full;
    int   h_falls;
    int   v_falls;
    int   h_period;
    int   h_low;
    int   de_run;
    int   de_lines;

    assign err_count_o   = errors;
    assign check_count_o = checks;

    task automatic compare_value(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
        end
    endtask

    function automatic int floor_sub(input int a, input int t);
        return (a > t) ? a - t : 0;
    endfunction

    // Expected colour from test pattern, window mask or scanline rule
    task automatic check_pixel(input int x, input int y);
        logic [2:0] row;
        int         thold;
        int         lvl;
        int         exp_r;
        int         exp_g;
        int         exp_b;
        string      name;
        if (mask_i.tp_en) begin
            name  = "test pattern";
            exp_r = (x ^ y) & 255;
            exp_g = exp_r;
            exp_b = exp_r;
        end else if (x >= int'(window_i.x_offset) &&
                     x < int'(window_i.x_offset) + int'(window_i.x_size) &&
                     y >= int'(window_i.y_offset) &&
                     y < int'(window_i.y_offset) + int'(window_i.y_size)) begin
            name  = "scanline";
            row   = 3'(y % (int'(sl_i.interval) + 1));
            thold = sl_i.overlay[row] ? (int'(sl_i.str[row]) + 1) * 16 - 1 : 0;
            exp_r = floor_sub(int'(pix_i.r), thold);
            exp_g = floor_sub(int'(pix_i.g), thold);
            exp_b = floor_sub(int'(pix_i.b), thold);
        end else begin
            name  = "mask";
            lvl   = int'(mask_i.br) * 17;
            exp_r = mask_i.color[2] ? lvl : 0;
            exp_g = mask_i.color[1] ? lvl : 0;
            exp_b = mask_i.color[0] ? lvl : 0;
        end
        compare_value({name, " R"}, exp_r, int'(r_i));
        compare_value({name, " G"}, exp_g, int'(g_i));
        compare_value({name, " B"}, exp_b, int'(b_i));
    endtask

    always @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            hsync_q    <= 1'b1;
            vsync_q    <= 1'b1;
            de_q       <= 1'b0;
            pulse_full <= 1'b0;
            h_falls    <= 0;
            v_falls    <= 0;
            h_period   <= 0;
            h_low      <= 0;
            de_run     <= 0;
            de_lines   <= 0;
        end else begin
            hsync_q <= hsync_i;
            vsync_q <= vsync_i;
            de_q    <= de_i;

            // First line after reset is one cycle short, so skip its pulse
            if (hsync_q && !hsync_i) begin
                if (h_falls >= 2) begin
                    compare_value("HSYNC period", int'(timing_i.h_total), h_period);
                end
                h_falls    <= h_falls + 1;
                h_period   <= 1;
                h_low      <= 1;
                pulse_full <= (h_falls >= 1);
            end else begin
                h_period <= h_period + 1;
                if (!hsync_i) begin
                    h_low <= h_low + 1;
                end
            end
            if (!hsync_q && hsync_i && pulse_full) begin
                compare_value("HSYNC low length", int'(timing_i.h_synclen), h_low);
            end

            // A frame runs from one VSYNC fall to the next
            if (vsync_q && !vsync_i) begin
                if (v_falls >= 1) begin
                    compare_value("DE lines per frame", int'(timing_i.v_active), de_lines);
                end
                v_falls  <= v_falls + 1;
                de_lines <= 0;
            end

            if (de_i) begin
                compare_value("xpos", de_q ? de_run : 0, int'(xpos_i));
                compare_value("ypos", de_lines, int'(ypos_i));
                check_pixel(int'(xpos_i), int'(ypos_i));
                de_run <= de_q ? de_run + 1 : 1;
            end else if (de_q) begin
                compare_value("DE cycles per line", int'(timing_i.h_active), de_run);
                de_lines <= de_lines + 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/scan_converter_top.sv
// Scan converter output stage top level
// Decode, timing and scanline execute, then output compose
`timescale 1ns/1ps
`default_nettype none

module scan_converter_top (
    input  wire                          PCLK_OUT_i,
    input  wire                          rst_n_i,
    input  wire [31:0]                   hv_cfg_i,
    input  wire [31:0]                   hv_cfg2_i,
    input  wire [31:0]                   hv_cfg3_i,
    input  wire [31:0]                   win_cfg_i,
    input  wire [31:0]                   sl_cfg_i,
    input  wire [31:0]                   misc_cfg_i,
    input  wire scan_pipe_pkg::pixel_t   pix_i,
    output logic [7:0]                   R_o,
    output logic [7:0]                   G_o,
    output logic [7:0]                   B_o,
    output logic                         HSYNC_o,
    output logic                         VSYNC_o,
    output logic                         DE_o,
    output logic [scan_cfg_pkg::H_W-1:0] xpos_o,
    output logic [scan_cfg_pkg::V_W-1:0] ypos_o
);
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    timing_cfg_t timing;
    window_cfg_t window;
    sl_cfg_t     sl_cfg;
    mask_cfg_t   mask_cfg;
    sync_t       sync_tg;
    sync_t       sync_out;
    pixel_t      pix_src;
    pixel_t      pix_sl;
    logic [2:0]  row_tg;
    logic [2:0]  row_sl;

    scan_cfg_decode scan_cfg_decode_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .hv_cfg_i   (hv_cfg_i),
        .hv_cfg2_i  (hv_cfg2_i),
        .hv_cfg3_i  (hv_cfg3_i),
        .win_cfg_i  (win_cfg_i),
        .sl_cfg_i   (sl_cfg_i),
        .misc_cfg_i (misc_cfg_i),
        .timing_o   (timing),
        .window_o   (window),
        .sl_o       (sl_cfg),
        .mask_o     (mask_cfg)
    );

    video_timing_gen video_timing_gen_inst (
        .PCLK_OUT_i    (PCLK_OUT_i),
        .rst_n_i       (rst_n_i),
        .timing_i      (timing),
        .sl_interval_i (sl_cfg.interval),
        .sync_o        (sync_tg),
        .row_idx_o     (row_tg)
    );

    // Sync waits for the scanlined pixel
    pipe_delay #(
        .T       (sync_t),
        .DEPTH   (PP_SL_END - PP_TIMING_END),
        .RST_VAL (SYNC_IDLE)
    ) sync_delay_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .d_i        (sync_tg),
        .q_o        (sync_out)
    );

    // Source capture of the external pixel
    pipe_delay #(
        .T     (pixel_t),
        .DEPTH (PP_SRC_END - PP_TIMING_END)
    ) pix_capture_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .d_i        (pix_i),
        .q_o        (pix_src)
    );

    // Row only changes at line wrap, so a late row still covers the active part
    pipe_delay #(
        .T     (logic [2:0]),
        .DEPTH (PP_SL_LENGTH)
    ) row_delay_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .d_i        (row_tg),
        .q_o        (row_sl)
    );

    scanline_gen scanline_gen_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .pix_i      (pix_src),
        .row_idx_i  (row_sl),
        .sl_i       (sl_cfg),
        .pix_o      (pix_sl)
    );

    output_compose output_compose_inst (
        .PCLK_OUT_i (PCLK_OUT_i),
        .rst_n_i    (rst_n_i),
        .sync_i     (sync_out),
        .pix_i      (pix_sl),
        .window_i   (window),
        .mask_i     (mask_cfg),
        .R_o        (R_o),
        .G_o        (G_o),
        .B_o        (B_o),
        .HSYNC_o    (HSYNC_o),
        .VSYNC_o    (VSYNC_o),
        .DE_o       (DE_o),
        .xpos_o     (xpos_o),
        .ypos_o     (ypos_o)
    );

endmodule

`default_nettype wire

//--- verilog/output_compose.sv
// Output stage with window border mask and x-xor-y test pattern
`timescale 1ns/1ps
`default_nettype none

module output_compose (
    input  wire                          PCLK_OUT_i,
    input  wire                          rst_n_i,
    input  wire scan_pipe_pkg::sync_t    sync_i,
    input  wire scan_pipe_pkg::pixel_t   pix_i,
    input  wire scan_cfg_pkg::window_cfg_t window_i,
    input  wire scan_cfg_pkg::mask_cfg_t mask_i,
    output logic [7:0]                   R_o,
    output logic [7:0]                   G_o,
    output logic [7:0]                   B_o,
    output logic                         HSYNC_o,
    output logic                         VSYNC_o,
    output logic                         DE_o,
    output logic [scan_cfg_pkg::H_W-1:0] xpos_o,
    output logic [scan_cfg_pkg::V_W-1:0] ypos_o
);
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    logic       x_in;
    logic       y_in;
    logic [7:0] tp_val;
    logic [7:0] mask_lvl;
    pixel_t     mask_pix;
    sync_t      sync_q;
    pixel_t     pix_q;

    // One extra bit so offset plus size cannot wrap
    assign x_in = (sync_i.xpos >= window_i.x_offset) &&
                  ((H_W+1)'(sync_i.xpos) < (H_W+1)'(window_i.x_offset) + window_i.x_size);
    assign y_in = (sync_i.ypos >= window_i.y_offset) &&
                  ((V_W+1)'(sync_i.ypos) < (V_W+1)'(window_i.y_offset) + window_i.y_size);

    assign tp_val   = sync_i.xpos[7:0] ^ sync_i.ypos[7:0];
    assign mask_lvl = {2{mask_i.br}};
    assign mask_pix = '{r: mask_i.color[2] ? mask_lvl : 8'h00,
                        g: mask_i.color[1] ? mask_lvl : 8'h00,
                        b: mask_i.color[0] ? mask_lvl : 8'h00};

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            sync_q <= SYNC_IDLE;
            pix_q  <= '0;
        end else begin
            sync_q <= sync_i;
            if (mask_i.tp_en) begin
                pix_q <= '{r: tp_val, g: tp_val, b: tp_val};
            end else if (x_in && y_in) begin
                pix_q <= pix_i;
            end else begin
                pix_q <= mask_pix;
            end
        end
    end

    assign R_o     = pix_q.r;
    assign G_o     = pix_q.g;
    assign B_o     = pix_q.b;
    assign HSYNC_o = sync_q.hsync;
    assign VSYNC_o = sync_q.vsync;
    assign DE_o    = sync_q.de;
    assign xpos_o  = sync_q.xpos;
    assign ypos_o  = sync_q.ypos;

endmodule

`default_nettype wire

//--- verilog/scanline_gen.sv
// Line-based scanline stage, two cycles
// Looks up the row strength, then subtracts it from each channel
`timescale 1ns/1ps
`default_nettype none

module scanline_gen (
    input  wire                      PCLK_OUT_i,
    input  wire scan_pipe_pkg::pixel_t pix_i,
    input  wire [2:0]                row_idx_i,
    input  wire scan_cfg_pkg::sl_cfg_t sl_i,
    output scan_pipe_pkg::pixel_t    pix_o
);
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    logic       row_on;
    logic [7:0] thold_q;
    pixel_t     pix_q;

    function automatic logic [7:0] sat_sub(input logic [7:0] a, input logic [7:0] b);
        return (a > b) ? a - b : 8'h00;
    endfunction

    // Rows past the last strength entry never draw
    assign row_on = (row_idx_i < 3'(SL_ROWS)) && sl_i.overlay[row_idx_i];

    // Cycle 1: threshold is (strength+1)*16-1
    always_ff @(posedge PCLK_OUT_i) begin
        pix_q <= pix_i;
        if (row_on) begin
            thold_q <= {sl_i.str[row_idx_i], 4'hf};
        end else begin
            thold_q <= 8'h00;
        end
    end

    // Cycle 2
    always_ff @(posedge PCLK_OUT_i) begin
        pix_o.r <= sat_sub(pix_q.r, thold_q);
        pix_o.g <= sat_sub(pix_q.g, thold_q);
        pix_o.b <= sat_sub(pix_q.b, thold_q);
    end

endmodule

`default_nettype wire

//--- verilog/pipe_delay.sv
// Fixed-depth register delay line for any packed payload type
`timescale 1ns/1ps
`default_nettype none

module pipe_delay #(
    parameter type T       = logic,
    parameter int  DEPTH   = 1,
    parameter T    RST_VAL = T'(0)
) (
    input  wire    PCLK_OUT_i,
    input  wire    rst_n_i,
    input  wire T  d_i,
    output T       q_o
);

    T pipe_q [DEPTH];

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                pipe_q[i] <= RST_VAL;
            end
        end else begin
            pipe_q[0] <= d_i;
            for (int i = 1; i < DEPTH; i++) begin
                pipe_q[i] <= pipe_q[i-1];
            end
        end
    end

    assign q_o = pipe_q[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/video_timing_gen.sv
// Free-running horizontal and vertical counters
// Produces HSYNC, VSYNC, DE, active x/y positions and the scanline row
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen (
    input  wire                        PCLK_OUT_i,
    input  wire                        rst_n_i,
    input  wire scan_cfg_pkg::timing_cfg_t timing_i,
    input  wire [2:0]                  sl_interval_i,
    output scan_pipe_pkg::sync_t       sync_o,
    output logic [2:0]                 row_idx_o
);
    import scan_cfg_pkg::*;
    import scan_pipe_pkg::*;

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic [V_W-1:0] v_next;
    logic           h_last;
    logic           h_in;
    logic           v_in;

    assign h_last = (h_cnt == timing_i.h_total - 1'b1);
    assign v_next = (v_cnt == timing_i.v_total - 1'b1) ? '0 : v_cnt + 1'b1;
    assign h_in   = (h_cnt >= timing_i.h_act_start) && (h_cnt < timing_i.h_act_end);
    assign v_in   = (v_cnt >= timing_i.v_act_start) && (v_cnt < timing_i.v_act_end);

    // Row index moves at the line wrap so it is steady over the whole line
    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            h_cnt     <= '0;
            v_cnt     <= '0;
            row_idx_o <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            v_cnt <= v_next;
            if ((v_next == timing_i.v_act_start) || (row_idx_o == sl_interval_i)) begin
                row_idx_o <= '0;
            end else begin
                row_idx_o <= row_idx_o + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            sync_o <= SYNC_IDLE;
        end else begin
            sync_o.hsync <= (h_cnt >= H_W'(timing_i.h_synclen));
            sync_o.vsync <= (v_cnt >= V_W'(timing_i.v_synclen));
            sync_o.de    <= h_in && v_in;
            // Positions only move inside the active area
            if (h_in && v_in) begin
                if (h_cnt == timing_i.h_act_start) begin
                    sync_o.xpos <= '0;
                    if (v_cnt == timing_i.v_act_start) begin
                        sync_o.ypos <= '0;
                    end else begin
                        sync_o.ypos <= sync_o.ypos + 1'b1;
                    end
                end else begin
                    sync_o.xpos <= sync_o.xpos + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/scan_cfg_decode.sv
// Configuration decoder for the output stage
// Splits raw 32-bit words into typed settings, registered once
`timescale 1ns/1ps
`default_nettype none

module scan_cfg_decode (
    input  wire                        PCLK_OUT_i,
    input  wire                        rst_n_i,
    input  wire [31:0]                 hv_cfg_i,
    input  wire [31:0]                 hv_cfg2_i,
    input  wire [31:0]                 hv_cfg3_i,
    input  wire [31:0]                 win_cfg_i,
    input  wire [31:0]                 sl_cfg_i,
    input  wire [31:0]                 misc_cfg_i,
    output scan_cfg_pkg::timing_cfg_t  timing_o,
    output scan_cfg_pkg::window_cfg_t  window_o,
    output scan_cfg_pkg::sl_cfg_t      sl_o,
    output scan_cfg_pkg::mask_cfg_t    mask_o
);
    import scan_cfg_pkg::*;

    logic [H_W-1:0] h_act_start;
    logic [V_W-1:0] v_act_start;

    // Sync plus back porch gives the first active count
    assign h_act_start = H_W'(hv_cfg_i[31:24]) + H_W'(hv_cfg2_i[8:0]);
    assign v_act_start = V_W'(hv_cfg3_i[3:0]) + V_W'(hv_cfg3_i[12:4]);

    always_ff @(posedge PCLK_OUT_i) begin
        if (!rst_n_i) begin
            timing_o <= '0;
            window_o <= '0;
            sl_o     <= '0;
            mask_o   <= '0;
        end else begin
            timing_o.h_total     <= hv_cfg_i[11:0];
            timing_o.h_active    <= hv_cfg_i[23:12];
            timing_o.h_synclen   <= hv_cfg_i[31:24];
            timing_o.h_backporch <= hv_cfg2_i[8:0];
            timing_o.v_total     <= hv_cfg2_i[19:9];
            timing_o.v_active    <= hv_cfg2_i[30:20];
            timing_o.v_synclen   <= hv_cfg3_i[3:0];
            timing_o.v_backporch <= hv_cfg3_i[12:4];
            timing_o.h_act_start <= h_act_start;
            timing_o.h_act_end   <= h_act_start + hv_cfg_i[23:12];
            timing_o.v_act_start <= v_act_start;
            timing_o.v_act_end   <= v_act_start + hv_cfg2_i[30:20];

            // Y offset rides in the upper part of the third timing word
            window_o.x_offset <= win_cfg_i[11:0];
            window_o.x_size   <= win_cfg_i[23:12];
            window_o.y_offset <= hv_cfg3_i[23:13];
            window_o.y_size   <= misc_cfg_i[18:8];

            sl_o.str      <= sl_cfg_i[23:0];
            sl_o.overlay  <= sl_cfg_i[29:24];
            sl_o.interval <= misc_cfg_i[21:19];

            mask_o.br    <= misc_cfg_i[3:0];
            mask_o.color <= misc_cfg_i[6:4];
            mask_o.tp_en <= misc_cfg_i[7];
        end
    end

endmodule

`default_nettype wire

//--- verilog/scan_pipe_pkg.sv
// Pipeline stage numbering for the output path
// Pixel and sync bundle types carried between stages
`default_nettype none

package scan_pipe_pkg;

    // Stage in which each block's result becomes valid
    localparam int PP_TIMING_END = 1;
    localparam int PP_SRC_END    = 2;
    localparam int PP_SL_LENGTH  = 2;
    localparam int PP_SL_END     = PP_SRC_END + PP_SL_LENGTH;
    localparam int PP_OUT_END    = PP_SL_END + 1;
    localparam int PP_LATENCY    = PP_OUT_END;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    typedef struct packed {
        logic                        hsync;
        logic                        vsync;
        logic                        de;
        logic [scan_cfg_pkg::H_W-1:0] xpos;
        logic [scan_cfg_pkg::V_W-1:0] ypos;
    } sync_t;

    // Inactive sync levels, syncs are active low
    localparam sync_t SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1, default: '0};

endpackage

`default_nettype wire

//--- verilog/scan_cfg_pkg.sv
// Configuration field types for the scan converter output stage
// Timing, window, scanline and mask settings with their bit widths
`default_nettype none

package scan_cfg_pkg;

    localparam int H_W     = 12;
    localparam int V_W     = 11;
    localparam int SL_ROWS = 6;

    // Raw timing fields plus precomputed active window bounds
    typedef struct packed {
        logic [H_W-1:0] h_total;
        logic [H_W-1:0] h_active;
        logic [7:0]     h_synclen;
        logic [8:0]     h_backporch;
        logic [V_W-1:0] v_total;
        logic [V_W-1:0] v_active;
        logic [3:0]     v_synclen;
        logic [8:0]     v_backporch;
        logic [H_W-1:0] h_act_start;
        logic [H_W-1:0] h_act_end;
        logic [V_W-1:0] v_act_start;
        logic [V_W-1:0] v_act_end;
    } timing_cfg_t;

    typedef struct packed {
        logic [H_W-1:0] x_offset;
        logic [H_W-1:0] x_size;
        logic [V_W-1:0] y_offset;
        logic [V_W-1:0] y_size;
    } window_cfg_t;

    // Entry 0 of str and overlay belongs to the first row of each group
    typedef struct packed {
        logic [SL_ROWS-1:0][3:0] str;
        logic [SL_ROWS-1:0]      overlay;
        logic [2:0]              interval;
    } sl_cfg_t;

    typedef struct packed {
        logic [3:0] br;
        logic [2:0] color;    // R, G, B enables from msb down
        logic       tp_en;
    } mask_cfg_t;

endpackage

`default_nettype wire
